// File: bus_arbiter_csr.sv
/* Arbiter control registers: data-first priority bit and counters of
   finished instruction and data transfers */
`timescale 1ns/10ps
`default_nettype none
`include "shared_bus_consts.svh"

module bus_arbiter_csr (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    sel,
    input  wire shared_bus_pkg::mem_req_t req,
    input  wire logic                    i_done,
    input  wire logic                    d_done,
    output logic                         ready,
    output logic [31:0]                  rdata,
    output logic                         dbus_first
);

    logic [31:0] icount;
    logic [31:0] dcount;
    logic [1:0]  offset;
    logic        wr_en;

    assign offset = req.addr[3:2];

    // Writes take effect in the ready cycle
    assign wr_en = sel && ready && (req.wstrb != 4'b0000);

    always_ff @(posedge clk) begin
        if (reset) begin
            ready      <= 1'b0;
            dbus_first <= 1'b0;
            icount     <= 32'd0;
            dcount     <= 32'd0;
        end else begin
            ready <= sel && !ready;

            if (wr_en && offset == `SB_CSR_CTRL && req.wstrb[0]) begin
                dbus_first <= req.wdata[0];
            end

            // A write clears the counter whatever the value written
            if (wr_en && offset == `SB_CSR_ICOUNT) begin
                icount <= 32'd0;
            end else if (i_done) begin
                icount <= icount + 32'd1;
            end

            if (wr_en && offset == `SB_CSR_DCOUNT) begin
                dcount <= 32'd0;
            end else if (d_done) begin
                dcount <= dcount + 32'd1;
            end
        end
    end

    // Read data is captured in the first bus cycle, before this
    // transfer's own done pulse reaches the counter
    always_ff @(posedge clk) begin
        if (sel && !ready) begin
            case (offset)
                `SB_CSR_CTRL:   rdata <= {31'd0, dbus_first};
                `SB_CSR_ICOUNT: rdata <= icount;
                `SB_CSR_DCOUNT: rdata <= dcount;
                default:        rdata <= 32'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: byte_ram.sv
/* On-chip RAM with byte write strobes, answering each select with a
   one-cycle registered ready */
`timescale 1ns/10ps
`default_nettype none
`include "shared_bus_consts.svh"

module byte_ram (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    sel,
    input  wire shared_bus_pkg::mem_req_t req,
    output logic                         ready,
    output logic [31:0]                  rdata
);

    logic [31:0] mem [0:`SB_RAM_WORDS-1];
    logic [`SB_RAM_ADDR_BITS-1:0] idx;

    // Upper address bits wrap around the RAM depth
    assign idx = req.addr[`SB_RAM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b0;
        end else begin
            ready <= sel && !ready;
        end
    end

    always_ff @(posedge clk) begin
        if (sel && ready) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end else begin
            rdata <= mem[idx];
        end
    end

    a_ready_with_sel: assert property (@(posedge clk) disable iff (reset)
        ready |-> sel);

endmodule

`default_nettype wire

// File: shared_bus_consts.svh
/* Shared bus constants: address width, RAM size, region bases and
   register offsets */
`ifndef SHARED_BUS_CONSTS_SVH
`define SHARED_BUS_CONSTS_SVH

`define SB_ADDR_WIDTH 32

// On-chip RAM depth in words and the matching word index width
`define SB_RAM_WORDS 256
`define SB_RAM_ADDR_BITS 8

// Register region, selected by address bit 31
`define SB_CSR_BASE 32'h8000_0000

// Word offsets inside the register region
`define SB_CSR_CTRL 2'd0
`define SB_CSR_ICOUNT 2'd1
`define SB_CSR_DCOUNT 2'd2

`endif

// File: shared_bus_decoder.sv
/* Shared bus decoder: picks RAM or the register block by address and
   returns the chosen target's ready and read data */
`timescale 1ns/10ps
`default_nettype none
`include "shared_bus_consts.svh"

module shared_bus_decoder (
    input  wire logic                    mem_valid,
    input  wire shared_bus_pkg::mem_req_t mem_req,
    input  wire logic                    ram_ready,
    input  wire logic [31:0]             ram_rdata,
    input  wire logic                    csr_ready,
    input  wire logic [31:0]             csr_rdata,
    output logic                         ram_sel,
    output logic                         csr_sel,
    output logic                         mem_ready,
    output logic [31:0]                  mem_rdata
);

    logic csr_hit;

    // The register region is the upper half of the address space
    assign csr_hit = |(mem_req.addr & `SB_CSR_BASE);

    assign ram_sel = mem_valid && !csr_hit;
    assign csr_sel = mem_valid && csr_hit;

    always_comb begin
        if (csr_hit) begin
            mem_ready = csr_ready;
            mem_rdata = csr_rdata;
        end else begin
            mem_ready = ram_ready;
            mem_rdata = ram_rdata;
        end
    end

endmodule

`default_nettype wire

// File: shared_bus_pkg.sv
/* Shared bus types: the split command payloads, the shared-bus request
   and the data access width */
`default_nettype none
`include "shared_bus_consts.svh"

package shared_bus_pkg;

    // Data access width, as log2 of the byte count
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    // Instruction fetch command
    typedef struct packed {
        logic [`SB_ADDR_WIDTH-1:0] pc;
    } ibus_cmd_t;

    // Data command, write data already sits in its byte lanes
    typedef struct packed {
        logic [`SB_ADDR_WIDTH-1:0] address;
        logic [31:0]               data;
        access_size_t              size;
        logic                      wr;
    } dbus_cmd_t;

    // Request on the shared bus, an all-zero strobe marks a read
    typedef struct packed {
        logic [`SB_ADDR_WIDTH-1:0] addr;
        logic [31:0]               wdata;
        logic [3:0]                wstrb;
    } mem_req_t;

endpackage

`default_nettype wire

// File: shared_bus_top.sv
/* Shared bus top: the split bus adapter with its priority registers,
   the address decoder and the on-chip RAM */
`timescale 1ns/10ps
`default_nettype none

module shared_bus_top (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    ibus_valid,
    input  wire shared_bus_pkg::ibus_cmd_t ibus_cmd,
    input  wire logic                    dbus_valid,
    input  wire shared_bus_pkg::dbus_cmd_t dbus_cmd,
    output logic                         ibus_ready,
    output logic                         ibus_rsp_valid,
    output logic [31:0]                  ibus_rsp_inst,
    output logic                         dbus_ready,
    output logic                         dbus_rsp_valid,
    output logic [31:0]                  dbus_rsp_data
);

    logic                     mem_valid;
    shared_bus_pkg::mem_req_t mem_req;
    logic                     mem_ready;
    logic [31:0]              mem_rdata;
    logic                     dbus_first;
    logic                     i_done;
    logic                     d_done;
    logic                     ram_sel;
    logic                     ram_ready;
    logic [31:0]              ram_rdata;
    logic                     csr_sel;
    logic                     csr_ready;
    logic [31:0]              csr_rdata;

    split_bus_adapter adapter (
        .clk            (clk),
        .reset          (reset),
        .ibus_valid     (ibus_valid),
        .ibus_cmd       (ibus_cmd),
        .dbus_valid     (dbus_valid),
        .dbus_cmd       (dbus_cmd),
        .dbus_first     (dbus_first),
        .mem_ready      (mem_ready),
        .mem_rdata      (mem_rdata),
        .ibus_ready     (ibus_ready),
        .ibus_rsp_valid (ibus_rsp_valid),
        .ibus_rsp_inst  (ibus_rsp_inst),
        .dbus_ready     (dbus_ready),
        .dbus_rsp_valid (dbus_rsp_valid),
        .dbus_rsp_data  (dbus_rsp_data),
        .mem_valid      (mem_valid),
        .mem_req        (mem_req),
        .i_done         (i_done),
        .d_done         (d_done)
    );

    bus_arbiter_csr csr (
        .clk        (clk),
        .reset      (reset),
        .sel        (csr_sel),
        .req        (mem_req),
        .i_done     (i_done),
        .d_done     (d_done),
        .ready      (csr_ready),
        .rdata      (csr_rdata),
        .dbus_first (dbus_first)
    );

    shared_bus_decoder decoder (
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .ram_ready (ram_ready),
        .ram_rdata (ram_rdata),
        .csr_ready (csr_ready),
        .csr_rdata (csr_rdata),
        .ram_sel   (ram_sel),
        .csr_sel   (csr_sel),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    byte_ram ram (
        .clk   (clk),
        .reset (reset),
        .sel   (ram_sel),
        .req   (mem_req),
        .ready (ram_ready),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: split_bus_adapter.sv
/* Split bus adapter: arbitrates instruction and data commands onto one
   shared valid/ready bus and steers the responses back */
`timescale 1ns/10ps
`default_nettype none

module split_bus_adapter (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    ibus_valid,
    input  wire shared_bus_pkg::ibus_cmd_t ibus_cmd,
    input  wire logic                    dbus_valid,
    input  wire shared_bus_pkg::dbus_cmd_t dbus_cmd,
    input  wire logic                    dbus_first,
    input  wire logic                    mem_ready,
    input  wire logic [31:0]             mem_rdata,
    output logic                         ibus_ready,
    output logic                         ibus_rsp_valid,
    output logic [31:0]                  ibus_rsp_inst,
    output logic                         dbus_ready,
    output logic                         dbus_rsp_valid,
    output logic [31:0]                  dbus_rsp_data,
    output logic                         mem_valid,
    output shared_bus_pkg::mem_req_t     mem_req,
    output logic                         i_done,
    output logic                         d_done
);

    logic       busy;
    logic       owner_d;
    logic       idle;
    logic       grant_i;
    logic       grant_d;
    logic [3:0] size_mask;
    logic [3:0] d_wstrb;

    // A finishing transfer frees the bus at the same edge
    assign idle = !busy || mem_ready;

    assign grant_d = idle && dbus_valid && (dbus_first || !ibus_valid);
    assign grant_i = idle && ibus_valid && !grant_d;

    always_comb begin
        case (dbus_cmd.size)
            shared_bus_pkg::SIZE_BYTE: size_mask = 4'b0001;
            shared_bus_pkg::SIZE_HALF: size_mask = 4'b0011;
            default:                   size_mask = 4'b1111;
        endcase
    end

    // One strobe bit per byte, moved to the addressed lane
    assign d_wstrb = dbus_cmd.wr ? size_mask << dbus_cmd.address[1:0] : 4'b0000;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            owner_d    <= 1'b0;
            ibus_ready <= 1'b0;
            dbus_ready <= 1'b0;
        end else begin
            ibus_ready <= grant_i;
            dbus_ready <= grant_d;
            if (grant_d || grant_i) begin
                busy    <= 1'b1;
                owner_d <= grant_d;
            end else if (idle) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_d) begin
            mem_req.addr  <= dbus_cmd.address;
            mem_req.wdata <= dbus_cmd.data;
            mem_req.wstrb <= d_wstrb;
        end else if (grant_i) begin
            mem_req.addr  <= ibus_cmd.pc;
            mem_req.wdata <= 32'h0000_0000;
            mem_req.wstrb <= 4'b0000;
        end
    end

    assign mem_valid = busy;

    // The owner flag decides which stream sees the finished transfer
    assign ibus_rsp_valid = busy && mem_ready && !owner_d;
    assign dbus_rsp_valid = busy && mem_ready && owner_d;
    assign ibus_rsp_inst  = mem_rdata;
    assign dbus_rsp_data  = mem_rdata;

    assign i_done = ibus_rsp_valid;
    assign d_done = dbus_rsp_valid;

    // The target may sample the request on any cycle until it answers
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        mem_valid && !mem_ready |=> $stable(mem_req));

    // The core must deliver word accesses on word boundaries
    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        dbus_valid && dbus_cmd.size == shared_bus_pkg::SIZE_WORD
        |-> dbus_cmd.address[1:0] == 2'b00);

    a_one_ready: assert property (@(posedge clk) disable iff (reset)
        !(ibus_ready && dbus_ready));

endmodule

`default_nettype wire

// File: tb_shared_bus.sv
/* Testbench for the shared bus top: plays the split-bus core, keeps a
   shadow model of RAM and counters and checks every response */
`timescale 1ns/10ps
`default_nettype none
`include "shared_bus_consts.svh"

module tb_shared_bus;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_WORDS   = 12;
    localparam int N_TRANSFERS = 5 * NUM_WORDS + 40;
    localparam int RSP_TIMEOUT = 20;
    localparam int WATCHDOG_NS = (N_TRANSFERS * 10 + 100) * CLK_PERIOD;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      ibus_valid;
    shared_bus_pkg::ibus_cmd_t ibus_cmd;
    logic                      dbus_valid;
    shared_bus_pkg::dbus_cmd_t dbus_cmd;
    logic                      ibus_ready;
    logic                      ibus_rsp_valid;
    logic [31:0]               ibus_rsp_inst;
    logic                      dbus_ready;
    logic                      dbus_rsp_valid;
    logic [31:0]               dbus_rsp_data;

    // Shadow model of RAM bytes and of the register block
    logic [7:0]  shadow_mem [0:1023];
    logic [31:0] shadow_i;
    logic [31:0] shadow_d;
    logic        shadow_first;

    logic [31:0] i_exp_addr[$];
    logic [31:0] i_exp_data[$];
    logic [31:0] d_exp_addr[$];
    logic [31:0] d_exp_data[$];
    logic        d_exp_chk[$];
    logic [31:0] cmp_addr;
    logic [31:0] cmp_data;
    logic        cmp_chk;

    logic [15:0] lfsr = 16'd47;
    logic [31:0] word_addr [0:NUM_WORDS-1];
    time         i_ready_at;
    time         d_ready_at;
    int          errors = 0;
    int          errors_before = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    shared_bus_top uut (
        .clk            (clk),
        .reset          (reset),
        .ibus_valid     (ibus_valid),
        .ibus_cmd       (ibus_cmd),
        .dbus_valid     (dbus_valid),
        .dbus_cmd       (dbus_cmd),
        .ibus_ready     (ibus_ready),
        .ibus_rsp_valid (ibus_rsp_valid),
        .ibus_rsp_inst  (ibus_rsp_inst),
        .dbus_ready     (dbus_ready),
        .dbus_rsp_valid (dbus_rsp_valid),
        .dbus_rsp_data  (dbus_rsp_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          k;
        v = 32'd0;
        for (k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] csr_addr(input logic [1:0] off);
        return `SB_CSR_BASE | {28'd0, off, 2'b00};
    endfunction

    // A run of ones, one per byte of the size, moved to the byte offset
    function automatic logic [3:0] ref_strobe(input shared_bus_pkg::access_size_t size,
                                              input logic [1:0] off);
        logic [3:0] ones;
        case (size)
            shared_bus_pkg::SIZE_BYTE: ones = 4'b0001;
            shared_bus_pkg::SIZE_HALF: ones = 4'b0011;
            default:                   ones = 4'b1111;
        endcase
        return ones << off;
    endfunction

    // Expected read data; counters read as they stood before this transfer
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [9:0] base;
        base = {addr[9:2], 2'b00};
        if (addr[31]) begin
            case (addr[3:2])
                `SB_CSR_CTRL:   return {31'd0, shadow_first};
                `SB_CSR_ICOUNT: return shadow_i;
                `SB_CSR_DCOUNT: return shadow_d;
                default:        return 32'd0;
            endcase
        end
        return {shadow_mem[base + 3], shadow_mem[base + 2],
                shadow_mem[base + 1], shadow_mem[base]};
    endfunction

    task automatic model_access(input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [3:0] strobe, input logic wr);
        int b;
        if (addr[31]) begin
            if (wr && addr[3:2] == `SB_CSR_ICOUNT) begin
                shadow_i = 32'd0;
                shadow_d++;
            end else if (wr && addr[3:2] == `SB_CSR_DCOUNT) begin
                // The clear wins over this write's own done pulse
                shadow_d = 32'd0;
            end else begin
                if (wr && addr[3:2] == `SB_CSR_CTRL && strobe[0]) begin
                    shadow_first = wdata[0];
                end
                shadow_d++;
            end
        end else begin
            for (b = 0; b < 4; b++) begin
                if (strobe[b]) begin
                    shadow_mem[{addr[9:2], 2'b00} + b] = wdata[8*b +: 8];
                end
            end
            shadow_d++;
        end
    endtask

    task automatic fetch(input logic [31:0] pc);
        int n;
        @(posedge clk);
        #2;
        ibus_cmd.pc = pc;
        ibus_valid  = 1'b1;
        i_exp_addr.push_back(pc);
        i_exp_data.push_back(ref_read(pc));
        shadow_i++;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ibus_ready && n < RSP_TIMEOUT);
        if (!ibus_ready) begin
            $display("Fetch at %h was never accepted", pc);
            errors++;
        end
        i_ready_at = $time;
        @(posedge clk);
        #2;
        ibus_valid = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ibus_rsp_valid && n < RSP_TIMEOUT);
        if (!ibus_rsp_valid) begin
            $display("Fetch at %h never got a response", pc);
            errors++;
        end
    endtask

    task automatic data_access(input logic [31:0] addr, input logic [31:0] wdata,
                               input shared_bus_pkg::access_size_t size, input logic wr);
        logic [3:0] strobe;
        int         n;
        strobe = wr ? ref_strobe(size, addr[1:0]) : 4'b0000;
        @(posedge clk);
        #2;
        dbus_cmd.address = addr;
        dbus_cmd.data    = wdata;
        dbus_cmd.size    = size;
        dbus_cmd.wr      = wr;
        dbus_valid       = 1'b1;
        d_exp_addr.push_back(addr);
        d_exp_data.push_back(wr ? 32'd0 : ref_read(addr));
        d_exp_chk.push_back(!wr);
        model_access(addr, wdata, strobe, wr);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!dbus_ready && n < RSP_TIMEOUT);
        if (!dbus_ready) begin
            $display("Data command at %h was never accepted", addr);
            errors++;
        end
        d_ready_at = $time;
        @(posedge clk);
        #2;
        dbus_valid = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!dbus_rsp_valid && n < RSP_TIMEOUT);
        if (!dbus_rsp_valid) begin
            $display("Data command at %h never got a response", addr);
            errors++;
        end
    endtask

    // Both streams raise valid at the same edge
    task automatic race_streams(input logic expect_data_first);
        logic data_won;
        fork
            fetch(word_addr[0]);
            data_access(word_addr[1], 32'd0, shared_bus_pkg::SIZE_WORD, 1'b0);
        join
        data_won = d_ready_at < i_ready_at;
        checks++;
        if (data_won != expect_data_first) begin
            $display("** Error (%0t): expected the %s stream to be granted first",
                     $time, expect_data_first ? "data" : "instruction");
            errors++;
        end
    endtask

    task automatic check_quiet(input string phase);
        checks++;
        if (ibus_ready || dbus_ready || ibus_rsp_valid || dbus_rsp_valid) begin
            $display("A ready or response pulse appeared %s with no command given", phase);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %-26s passed", name);
        end else begin
            tests_failed++;
            $display("Test %-26s failed with %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    // Compare every response pulse with the oldest expectation of its stream
    always @(negedge clk) begin
        if (ibus_rsp_valid) begin
            if (i_exp_data.size() == 0) begin
                $display("Instruction response arrived with no fetch outstanding");
                errors++;
            end else begin
                cmp_addr = i_exp_addr.pop_front();
                cmp_data = i_exp_data.pop_front();
                checks++;
                if (ibus_rsp_inst !== cmp_data) begin
                    $display("** Error (%0t): fetch at %h returned %h, expected %h",
                             $time, cmp_addr, ibus_rsp_inst, cmp_data);
                    errors++;
                end
            end
        end
        if (dbus_rsp_valid) begin
            if (d_exp_data.size() == 0) begin
                $display("Data response arrived with no command outstanding");
                errors++;
            end else begin
                cmp_addr = d_exp_addr.pop_front();
                cmp_data = d_exp_data.pop_front();
                cmp_chk  = d_exp_chk.pop_front();
                checks++;
                if (cmp_chk && dbus_rsp_data !== cmp_data) begin
                    $display("** Error (%0t): data read at %h returned %h, expected %h",
                             $time, cmp_addr, dbus_rsp_data, cmp_data);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0]                  r;
        logic [1:0]                   off;
        int                           i;
        int                           k;
        shared_bus_pkg::access_size_t sz;

        reset        = 1'b1;
        ibus_valid   = 1'b0;
        ibus_cmd     = '0;
        dbus_valid   = 1'b0;
        dbus_cmd     = '0;
        shadow_i     = 32'd0;
        shadow_d     = 32'd0;
        shadow_first = 1'b0;

        repeat (5) begin
            @(posedge clk);
            #2;
            check_quiet("during reset");
        end
        reset = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_quiet("after reset");
        end
        end_test("reset state");

        for (i = 0; i < NUM_WORDS; i++) begin
            r = take_bits(8);
            word_addr[i] = {22'd0, r[7:0], 2'b00};
            data_access(word_addr[i], take_bits(32), shared_bus_pkg::SIZE_WORD, 1'b1);
        end
        for (i = 0; i < NUM_WORDS; i++) begin
            data_access(word_addr[i], 32'd0, shared_bus_pkg::SIZE_WORD, 1'b0);
        end
        end_test("word write and read-back");

        // Partial writes land only in the strobed lanes of a written word
        for (i = 0; i < NUM_WORDS; i++) begin
            r  = take_bits(4);
            k  = r % NUM_WORDS;
            r  = take_bits(2);
            sz = shared_bus_pkg::access_size_t'(r % 3);
            r  = take_bits(2);
            off = r[1:0];
            if (sz == shared_bus_pkg::SIZE_HALF) begin
                off[0] = 1'b0;
            end else if (sz == shared_bus_pkg::SIZE_WORD) begin
                off = 2'b00;
            end
            data_access({word_addr[k][31:2], off}, take_bits(32), sz, 1'b1);
            data_access(word_addr[k], 32'd0, shared_bus_pkg::SIZE_WORD, 1'b0);
        end
        end_test("byte and halfword writes");

        for (i = 0; i < NUM_WORDS; i++) begin
            fetch(word_addr[i]);
        end
        end_test("instruction fetch");

        race_streams(1'b0);
        data_access(csr_addr(`SB_CSR_CTRL), 32'd1, shared_bus_pkg::SIZE_WORD, 1'b1);
        race_streams(1'b1);
        data_access(csr_addr(`SB_CSR_CTRL), 32'd0, shared_bus_pkg::SIZE_WORD, 1'b0);
        data_access(csr_addr(`SB_CSR_CTRL), 32'd0, shared_bus_pkg::SIZE_WORD, 1'b1);
        end_test("arbitration priority");

        repeat (3) fetch(word_addr[2]);
        repeat (2) data_access(word_addr[3], 32'd0, shared_bus_pkg::SIZE_WORD, 1'b0);
        data_access(csr_addr(`SB_CSR_ICOUNT), 32'd0, shared_bus_pkg::SIZE_WORD, 1'b0);
        data_access(csr_addr(`SB_CSR_DCOUNT), 32'd0, shared_bus_pkg::SIZE_WORD, 1'b0);
        data_access(csr_addr(`SB_CSR_DCOUNT), 32'd0, shared_bus_pkg::SIZE_WORD, 1'b0);
        data_access(csr_addr(`SB_CSR_ICOUNT), 32'hFFFF_FFFF, shared_bus_pkg::SIZE_WORD, 1'b1);
        data_access(csr_addr(`SB_CSR_ICOUNT), 32'd0, shared_bus_pkg::SIZE_WORD, 1'b0);
        repeat (2) fetch(word_addr[4]);
        data_access(csr_addr(`SB_CSR_ICOUNT), 32'd0, shared_bus_pkg::SIZE_WORD, 1'b0);
        data_access(csr_addr(`SB_CSR_DCOUNT), 32'h1234_5678, shared_bus_pkg::SIZE_WORD, 1'b1);
        data_access(csr_addr(`SB_CSR_DCOUNT), 32'd0, shared_bus_pkg::SIZE_WORD, 1'b0);
        end_test("transfer counters");

        $display("Tests: %0d run, %0d failed; checks: %0d; errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
shared_bus_pkg.sv
split_bus_adapter.sv
bus_arbiter_csr.sv
shared_bus_decoder.sv
byte_ram.sv
shared_bus_top.sv
tb_shared_bus.sv
